/* dispatch_stage.f */
+incdir+source
source/dispatch_pkg.sv
source/lane_if.sv
source/inst_buffer.sv
source/lane_decode.sv
source/dispatch_select.sv
source/dispatch_stage.sv
dv/dispatch_checker.sv
dv/dispatch_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dispatch_stage_tb -f dispatch_stage.f -o dispatch_sim
./obj_dir/dispatch_sim | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* dv/dispatch_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_defines.svh"

module dispatch_stage_tb;
    localparam int N          = `DISP_N;
    localparam int CW         = `DISP_CNT_W;
    localparam int TW         = $clog2(`SQ_SZ);
    localparam int RST_CYCLES = 16;

    localparam logic [6:0] OP_ALU = 7'h33;
    localparam logic [6:0] OP_LD  = 7'h03;
    localparam logic [6:0] OP_ST  = 7'h23;
    localparam logic [6:0] OP_BR  = 7'h63;
    localparam logic [6:0] OP_JAL = 7'h6f;
    localparam logic [6:0] OP_BAD = 7'h7f;
    // opcode pool for random rows with op-imm and jalr
    localparam logic [6:0] OPC_MIX [8] = '{
        OP_ALU, 7'h13, OP_LD, OP_ST, OP_BR, OP_JAL, 7'h67, OP_BAD
    };

    typedef struct {
        logic [N-1:0]       valid;
        logic [N-1:0][31:0] insts;
        logic [CW-1:0]      rob, rs, sq;
        logic [TW-1:0]      tail;
        logic               bs;
        int                 hold;
        logic               has_exp;
        logic [CW-1:0]      num, st;
    } row_t;

    logic                 clock;
    logic                 rst;
    logic                 fetch_req;
    logic [N-1:0]         fetch_valid;
    logic [N-1:0][31:0]   fetch_insts;
    logic [CW-1:0]        rob_open, rs_open, sq_open;
    logic [TW-1:0]        sq_tail;
    logic                 bs_full;
    logic                 fetch_ack;
    logic [CW-1:0]        num_dispatch, num_store_dispatched;
    logic [N-1:0]         disp_valid, disp_illegal;
    logic [N-1:0][31:0]   disp_insts;
    logic [N-1:0][2:0]    disp_class;
    logic [N-1:0][TW-1:0] disp_sq_tag;
    logic                 exp_en;
    logic [CW-1:0]        exp_num, exp_store;

    row_t        rows[$];
    logic [31:0] lfsr;
    int          cycles;
    int          cycle_limit;
    int          errs_before;

    always #4 clock = ~clock;

    dispatch_stage i_dut (.*);

    dispatch_checker dispatch_checker (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // k spreads the register fields so lanes stay distinct
    function automatic logic [31:0] encode(input logic [6:0] op, input int k);
        return {7'd0, 5'(k + 2), 5'(k + 1), 3'b010, 5'(k), op};
    endfunction

    function automatic logic [CW-1:0] clamp_open(input logic [31:0] v);
        return CW'((v > N) ? N : v);
    endfunction

    task automatic add_row(input logic [N-1:0] valid, input logic [31:0] i0, i1, i2, i3,
                           input int rob, rs, sq, tail, bs, hold, num, st);
        row_t r;
        r.valid   = valid;
        r.insts   = {i3, i2, i1, i0};
        r.rob     = CW'(rob);
        r.rs      = CW'(rs);
        r.sq      = CW'(sq);
        r.tail    = TW'(tail);
        r.bs      = 1'(bs);
        r.hold    = hold;
        r.has_exp = 1'b1;
        r.num     = CW'(num);
        r.st      = CW'(st);
        rows.push_back(r);
    endtask

    task automatic add_filler();
        row_t        r;
        logic [31:0] nv;
        logic [31:0] sel;
        logic [31:0] v;
        take_bits(2, nv);
        for (int i = 0; i < N; i++) begin
            take_bits(3, sel);
            take_bits(25, v);
            r.valid[i] = (i <= int'(nv));
            r.insts[i] = {v[24:0], OPC_MIX[sel[2:0]]};
        end
        take_bits(3, v);
        r.rob = clamp_open(v);
        take_bits(3, v);
        r.rs = clamp_open(v);
        take_bits(3, v);
        r.sq = clamp_open(v);
        take_bits(TW, v);
        r.tail = TW'(v);
        take_bits(1, v);
        r.bs      = v[0];
        r.hold    = 1;
        r.has_exp = 1'b0;
        r.num     = '0;
        r.st      = '0;
        rows.push_back(r);
    endtask

    // one bundle through handshake and hold cycles until the buffer drains
    task automatic run_row(input row_t r);
        fetch_req   = 1'b1;
        fetch_valid = r.valid;
        fetch_insts = r.insts;
        rob_open    = r.rob;
        rs_open     = r.rs;
        sq_open     = r.sq;
        sq_tail     = r.tail;
        bs_full     = r.bs;
        exp_num     = r.num;
        exp_store   = r.st;
        @(negedge clock);
        while (!fetch_ack) begin
            @(negedge clock);
        end
        // first dispatch cycle of the bundle
        exp_en = r.has_exp;
        // fetch_req stays high over the hold cycles and must not cause a second accept
        repeat (r.hold) begin
            @(negedge clock);
            exp_en = 1'b0;
        end
        fetch_req = 1'b0;
        rob_open  = CW'(N);
        rs_open   = CW'(N);
        sq_open   = CW'(N);
        bs_full   = 1'b0;
        while (fetch_ack) begin
            @(negedge clock);
        end
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, a fetch handshake never completed", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clock       = 1'b0;
        rst         = 1'b1;
        fetch_req   = 1'b0;
        fetch_valid = '0;
        fetch_insts = '0;
        rob_open    = '0;
        rs_open     = '0;
        sq_open     = '0;
        sq_tail     = '0;
        bs_full     = 1'b0;
        exp_en      = 1'b0;
        exp_num     = '0;
        exp_store   = '0;
        lfsr        = 32'h1a69ae99;
        cycles      = 0;
        // valid, lanes 0..3, rob rs sq tail bs hold, expected num and stores
        add_row(4'b1111, encode(OP_ALU, 1), encode(OP_ALU, 4), encode(OP_ALU, 7),
                encode(OP_ALU, 10), 4, 4, 4, 0, 0, 1, 4, 0);
        add_row(4'b1111, encode(OP_ALU, 2), encode(OP_ALU, 5), encode(OP_ALU, 8),
                encode(OP_ALU, 11), 2, 3, 4, 0, 0, 1, 2, 0);
        add_row(4'b0111, encode(OP_ALU, 3), encode(OP_ALU, 6), encode(OP_ALU, 9),
                encode(OP_ALU, 12), 4, 1, 4, 0, 0, 1, 1, 0);
        add_row(4'b1111, encode(OP_BR, 1), encode(OP_ALU, 2), encode(OP_ALU, 3),
                encode(OP_ALU, 4), 4, 4, 4, 0, 0, 1, 4, 0);
        add_row(4'b1111, encode(OP_BR, 5), encode(OP_ALU, 6), encode(OP_ALU, 7),
                encode(OP_ALU, 8), 4, 4, 4, 0, 1, 1, 0, 0);
        add_row(4'b1111, encode(OP_ALU, 9), encode(OP_ALU, 10), encode(OP_BR, 11),
                encode(OP_ALU, 12), 4, 4, 4, 0, 0, 1, 2, 0);
        add_row(4'b0011, encode(OP_JAL, 1), encode(OP_JAL, 2), encode(OP_ALU, 3),
                encode(OP_ALU, 4), 4, 4, 4, 0, 0, 1, 1, 0);
        add_row(4'b1111, encode(OP_ST, 5), encode(OP_LD, 6), encode(OP_ST, 7),
                encode(OP_ST, 8), 4, 4, 2, 14, 0, 1, 3, 2);
        add_row(4'b1111, encode(OP_LD, 9), encode(OP_ST, 10), encode(OP_LD, 11),
                encode(OP_ST, 12), 4, 4, 4, 15, 0, 1, 4, 2);
        add_row(4'b0111, encode(OP_BAD, 1), encode(OP_ALU, 2), encode(OP_BAD, 3),
                encode(OP_ALU, 4), 4, 4, 4, 0, 0, 1, 3, 0);
        add_row(4'b0011, encode(OP_ALU, 5), encode(OP_ALU, 6), encode(OP_ALU, 7),
                encode(OP_ALU, 8), 0, 4, 4, 0, 0, 4, 0, 0);
        add_row(4'b1111, encode(OP_ST, 9), encode(OP_ALU, 10), encode(OP_ALU, 11),
                encode(OP_ALU, 12), 4, 4, 0, 3, 0, 3, 0, 0);
        repeat (12) add_filler();
        cycle_limit = rows.size() * (N + 8) + RST_CYCLES;

        repeat (RST_CYCLES) @(negedge clock);
        rst = 1'b0;
        // idle cycles so the checker sees the post-reset outputs
        repeat (3) @(negedge clock);
        foreach (rows[k]) begin
            errs_before = dispatch_checker.err_cnt;
            run_row(rows[k]);
            $display("row %0d done, %0d new errors", k, dispatch_checker.err_cnt - errs_before);
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), dispatch_checker.chk_cnt,
                 dispatch_checker.err_cnt);
        if (dispatch_checker.err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/dispatch_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_defines.svh"

module dispatch_checker (
    input logic                                clock,
    input logic                                rst,
    input logic                                fetch_req,
    input logic [`DISP_N-1:0]                  fetch_valid,
    input logic [`DISP_N-1:0][31:0]            fetch_insts,
    input logic [`DISP_CNT_W-1:0]              rob_open,
    input logic [`DISP_CNT_W-1:0]              rs_open,
    input logic [`DISP_CNT_W-1:0]              sq_open,
    input logic [$clog2(`SQ_SZ)-1:0]           sq_tail,
    input logic                                bs_full,
    input logic                                fetch_ack,
    input logic [`DISP_CNT_W-1:0]              num_dispatch,
    input logic [`DISP_CNT_W-1:0]              num_store_dispatched,
    input logic [`DISP_N-1:0]                  disp_valid,
    input logic [`DISP_N-1:0][31:0]            disp_insts,
    input logic [`DISP_N-1:0][2:0]             disp_class,
    input logic [`DISP_N-1:0][$clog2(`SQ_SZ)-1:0] disp_sq_tag,
    input logic [`DISP_N-1:0]                  disp_illegal,
    input logic                                exp_en,
    input logic [`DISP_CNT_W-1:0]              exp_num,
    input logic [`DISP_CNT_W-1:0]              exp_store
);
    localparam int N  = `DISP_N;
    localparam int TW = $clog2(`SQ_SZ);

    // model of the buffer, packed from lane 0
    logic [N-1:0]       m_valid;
    logic [N-1:0][31:0] m_inst;
    logic               m_ack;
    int                 err_cnt = 0;
    int                 chk_cnt = 0;

    // codes in enum order: alu, load, store, branch, illegal
    function automatic logic [2:0] class_of(input logic [31:0] w);
        case (w[6:0])
            7'h33, 7'h13, 7'h37, 7'h17: return 3'd0;
            7'h03: return 3'd1;
            7'h23: return 3'd2;
            7'h63, 7'h6f, 7'h67: return 3'd3;
            default: return 3'd4;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    always @(posedge clock) begin
        logic [N-1:0]         e_valid;
        logic [N-1:0][31:0]   e_inst;
        logic [N-1:0][2:0]    e_cls;
        logic [N-1:0][TW-1:0] e_tag;
        logic [2:0]           cls;
        int                   occ, lim, n_disp, n_st;
        logic                 stop;

        if (rst) begin
            m_valid = '0;
            m_ack   = 1'b0;
        end else begin
            e_valid = '0;
            e_inst  = '0;
            e_cls   = '0;
            e_tag   = '0;
            n_disp  = 0;
            n_st    = 0;
            stop    = 1'b0;
            occ     = $countones(m_valid);
            lim     = occ;
            if (int'(rob_open) < lim) lim = int'(rob_open);
            if (int'(rs_open) < lim) lim = int'(rs_open);
            for (int i = 0; i < N; i++) begin
                cls = class_of(m_inst[i]);
                if (!stop && m_valid[i] && i < lim && !(cls == 3'd3 && (i != 0 || bs_full))
                    && !(cls == 3'd2 && n_st >= int'(sq_open))) begin
                    e_valid[i] = 1'b1;
                    e_inst[i]  = m_inst[i];
                    e_cls[i]   = cls;
                    if (cls == 3'd1 || cls == 3'd2) e_tag[i] = TW'(int'(sq_tail) + n_st);
                    if (cls == 3'd2) n_st++;
                    n_disp++;
                end else begin
                    stop = 1'b1;
                end
            end

            compare("fetch_ack", 32'(fetch_ack), 32'(m_ack));
            compare("num_dispatch", 32'(num_dispatch), n_disp);
            compare("num_store_dispatched", 32'(num_store_dispatched), n_st);
            for (int i = 0; i < N; i++) begin
                compare($sformatf("disp_valid[%0d]", i), 32'(disp_valid[i]), 32'(e_valid[i]));
                compare($sformatf("disp_insts[%0d]", i), disp_insts[i], e_inst[i]);
                compare($sformatf("disp_class[%0d]", i), 32'(disp_class[i]), 32'(e_cls[i]));
                compare($sformatf("disp_sq_tag[%0d]", i), 32'(disp_sq_tag[i]), 32'(e_tag[i]));
                compare($sformatf("disp_illegal[%0d]", i), 32'(disp_illegal[i]),
                        32'(e_valid[i] && e_cls[i] == 3'd4));
            end
            if (exp_en) begin
                compare("num_dispatch (table)", 32'(num_dispatch), 32'(exp_num));
                compare("num_store_dispatched (table)", 32'(num_store_dispatched), 32'(exp_store));
            end

            // accept only into an empty buffer with the last handshake closed
            if (fetch_req && !m_ack && occ == 0) begin
                m_valid = fetch_valid;
                m_inst  = fetch_insts;
                m_ack   = 1'b1;
            end else begin
                if (m_ack && !fetch_req && occ == n_disp) m_ack = 1'b0;
                for (int i = 0; i < N; i++) begin
                    m_valid[i] = (i + n_disp < N) ? m_valid[i + n_disp] : 1'b0;
                    m_inst[i]  = (i + n_disp < N) ? m_inst[i + n_disp] : 32'd0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/dispatch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_defines.svh"

module dispatch_stage (
    input  logic                                           clock,
    input  logic                                           rst,
    input  logic                                           fetch_req,
    input  logic [`DISP_N-1:0]                             fetch_valid,
    input  logic [`DISP_N-1:0][31:0]                       fetch_insts,
    input  logic [`DISP_CNT_W-1:0]                         rob_open,
    input  logic [`DISP_CNT_W-1:0]                         rs_open,
    input  logic [`DISP_CNT_W-1:0]                         sq_open,
    input  logic [dispatch_pkg::SQ_TAG_W-1:0]              sq_tail,
    input  logic                                           bs_full,
    output logic                                           fetch_ack,
    output logic [`DISP_CNT_W-1:0]                         num_dispatch,
    output logic [`DISP_CNT_W-1:0]                         num_store_dispatched,
    output logic [`DISP_N-1:0]                             disp_valid,
    output logic [`DISP_N-1:0][31:0]                       disp_insts,
    output logic [`DISP_N-1:0][2:0]                        disp_class,
    output logic [`DISP_N-1:0][dispatch_pkg::SQ_TAG_W-1:0] disp_sq_tag,
    output logic [`DISP_N-1:0]                             disp_illegal
);
    import dispatch_pkg::*;

    fetch_slot_t [`DISP_N-1:0]   slots;
    decoded_inst_t [`DISP_N-1:0] disp_packets;

    lane_if lanes [`DISP_N-1:0] ();

    inst_buffer i_buffer (
        .clock        (clock),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_valid  (fetch_valid),
        .fetch_insts  (fetch_insts),
        .num_dispatch (num_dispatch),
        .fetch_ack    (fetch_ack),
        .slots        (slots)
    );

    for (genvar g = 0; g < `DISP_N; g++) begin : g_lane
        lane_decode i_decode (
            .slot (slots[g]),
            .lane (lanes[g])
        );

        // flatten the packet for the back end
        assign disp_valid[g]   = disp_packets[g].valid;
        assign disp_insts[g]   = disp_packets[g].inst;
        assign disp_class[g]   = disp_packets[g].cls;
        assign disp_sq_tag[g]  = disp_packets[g].sq_tag;
        assign disp_illegal[g] = disp_packets[g].illegal;
    end

    dispatch_select i_select (
        .clock                (clock),
        .rst                  (rst),
        .lanes                (lanes),
        .rob_open             (rob_open),
        .rs_open              (rs_open),
        .sq_open              (sq_open),
        .sq_tail              (sq_tail),
        .bs_full              (bs_full),
        .num_dispatch         (num_dispatch),
        .num_store_dispatched (num_store_dispatched),
        .disp_packets         (disp_packets)
    );

endmodule

`default_nettype wire

/* source/dispatch_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_defines.svh"

module dispatch_select (
    input  logic                                     clock,
    input  logic                                     rst,
    lane_if.selector                                 lanes [`DISP_N-1:0],
    input  logic [`DISP_CNT_W-1:0]                   rob_open,
    input  logic [`DISP_CNT_W-1:0]                   rs_open,
    input  logic [`DISP_CNT_W-1:0]                   sq_open,
    input  logic [dispatch_pkg::SQ_TAG_W-1:0]        sq_tail,
    input  logic                                     bs_full,
    output logic [`DISP_CNT_W-1:0]                   num_dispatch,
    output logic [`DISP_CNT_W-1:0]                   num_store_dispatched,
    output dispatch_pkg::decoded_inst_t [`DISP_N-1:0] disp_packets
);
    import dispatch_pkg::*;

    decoded_inst_t [`DISP_N-1:0] lane_pkt;
    logic [`DISP_N-1:0]          lane_valid;
    logic [`DISP_N-1:0]          lane_branch;
    logic [`DISP_N-1:0]          lane_mem;
    logic [`DISP_CNT_W-1:0]      valid_cnt;
    logic [`DISP_CNT_W-1:0]      rob_rs_min;
    logic [`DISP_CNT_W-1:0]      limit;

    // interface arrays cannot be indexed by a loop variable
    for (genvar g = 0; g < `DISP_N; g++) begin : g_unpack
        assign lane_pkt[g]    = lanes[g].pkt;
        assign lane_valid[g]  = lanes[g].valid;
        assign lane_branch[g] = lanes[g].is_branch;
        assign lane_mem[g]    = lanes[g].is_mem;
    end

    always_comb begin
        valid_cnt = '0;
        for (int i = 0; i < `DISP_N; i++) begin
            if (lane_valid[i]) begin
                valid_cnt = valid_cnt + `DISP_CNT_W'(1);
            end
        end
    end

    assign rob_rs_min = (rob_open < rs_open) ? rob_open : rs_open;
    assign limit      = (valid_cnt < rob_rs_min) ? valid_cnt : rob_rs_min;

    // in-order walk, the first lane that cannot go stops the rest
    always_comb begin
        logic stop;
        logic is_store;

        num_dispatch         = '0;
        num_store_dispatched = '0;
        disp_packets         = '0;
        stop                 = 1'b0;

        for (int i = 0; i < `DISP_N; i++) begin
            is_store = lane_mem[i] && (lane_pkt[i].cls == CLS_STORE);
            if (stop || !lane_valid[i] || i >= int'(limit)) begin
                stop = 1'b1;
            end else if (lane_branch[i] && (i != 0 || bs_full)) begin
                // branch stack tracks one branch per cycle
                stop = 1'b1;
            end else if (is_store && num_store_dispatched >= sq_open) begin
                stop = 1'b1;
            end else begin
                disp_packets[i] = lane_pkt[i];
                if (lane_mem[i]) begin
                    // loads take the next free store slot as their tag
                    disp_packets[i].sq_tag = sq_tail + SQ_TAG_W'(num_store_dispatched);
                end
                if (is_store) begin
                    num_store_dispatched = num_store_dispatched + `DISP_CNT_W'(1);
                end
                num_dispatch = num_dispatch + `DISP_CNT_W'(1);
            end
        end
    end

    disp_within_rob_rs: assert property (@(posedge clock) disable iff (rst)
        (num_dispatch <= rob_open) && (num_dispatch <= rs_open));

    stores_within_sq: assert property (@(posedge clock) disable iff (rst)
        num_store_dispatched <= sq_open);

endmodule

`default_nettype wire

/* source/lane_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_decode (
    input dispatch_pkg::fetch_slot_t slot,
    lane_if.decoder                  lane
);
    import dispatch_pkg::*;

    logic [6:0]    opcode;
    inst_class_t   cls;
    logic          writes_rd;
    decoded_inst_t pkt;

    assign opcode = slot.inst[6:0];

    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                cls = CLS_ALU;
            end
            OPC_LOAD: begin
                cls = CLS_LOAD;
            end
            OPC_STORE: begin
                cls = CLS_STORE;
            end
            OPC_BRANCH, OPC_JAL, OPC_JALR: begin
                cls = CLS_BRANCH;
            end
            default: begin
                cls = CLS_ILLEGAL;
            end
        endcase
    end

    // stores and conditional branches have no destination
    // jal and jalr still write the link register
    assign writes_rd = (opcode != OPC_STORE) && (opcode != OPC_BRANCH);

    always_comb begin
        pkt = '0;
        if (slot.valid) begin
            pkt.valid   = 1'b1;
            pkt.cls     = cls;
            pkt.illegal = (cls == CLS_ILLEGAL);
            // raw fields, the back end ignores those the format lacks
            pkt.rd      = slot.inst[11:7];
            pkt.rs1     = slot.inst[19:15];
            pkt.rs2     = slot.inst[24:20];
            pkt.uses_rd = writes_rd;
            pkt.inst    = slot.inst;
        end
    end

    assign lane.valid     = pkt.valid;
    assign lane.pkt       = pkt;
    assign lane.is_branch = pkt.valid && (cls == CLS_BRANCH);
    assign lane.is_mem    = pkt.valid && (cls == CLS_LOAD || cls == CLS_STORE);

endmodule

`default_nettype wire

/* source/inst_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_defines.svh"

module inst_buffer (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   fetch_req,
    input  logic [`DISP_N-1:0]                     fetch_valid,
    input  logic [`DISP_N-1:0][31:0]               fetch_insts,
    input  logic [`DISP_CNT_W-1:0]                 num_dispatch,
    output logic                                   fetch_ack,
    output dispatch_pkg::fetch_slot_t [`DISP_N-1:0] slots
);
    import dispatch_pkg::*;

    logic [`DISP_N-1:0]       slot_valid;
    logic [`DISP_N-1:0][31:0] slot_inst;
    logic [`DISP_CNT_W-1:0]   occ_cnt;
    logic [`DISP_CNT_W-1:0]   remain_cnt;
    logic                     buf_empty;
    logic                     accept;
    fetch_slot_t [`DISP_N-1:0] shifted;

    always_comb begin
        for (int i = 0; i < `DISP_N; i++) begin
            slots[i].valid = slot_valid[i];
            slots[i].inst  = slot_inst[i];
        end
    end

    // valid entries are packed from lane 0
    always_comb begin
        occ_cnt = '0;
        for (int i = 0; i < `DISP_N; i++) begin
            if (slot_valid[i]) begin
                occ_cnt = occ_cnt + `DISP_CNT_W'(1);
            end
        end
    end

    assign buf_empty  = (occ_cnt == '0);
    assign remain_cnt = occ_cnt - num_dispatch;
    // take a new bundle only when drained and the last handshake has closed
    assign accept     = fetch_req && !fetch_ack && buf_empty;

    // drop the dispatched entries and move the rest toward lane 0
    always_comb begin
        for (int i = 0; i < `DISP_N; i++) begin
            if (i + int'(num_dispatch) < `DISP_N) begin
                shifted[i] = slots[i + int'(num_dispatch)];
            end else begin
                shifted[i] = '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            fetch_ack  <= 1'b0;
            slot_valid <= '0;
        end else begin
            if (accept) begin
                fetch_ack <= 1'b1;
            end else if (fetch_ack && !fetch_req && remain_cnt == '0) begin
                // ack falls once req is gone and the bundle has left
                fetch_ack <= 1'b0;
            end
            for (int i = 0; i < `DISP_N; i++) begin
                slot_valid[i] <= accept ? fetch_valid[i] : shifted[i].valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `DISP_N; i++) begin
            slot_inst[i] <= accept ? fetch_insts[i] : shifted[i].inst;
        end
    end

    ack_needs_req: assert property (@(posedge clock) disable iff (rst)
        $rose(fetch_ack) |-> $past(fetch_req));

    disp_within_occ: assert property (@(posedge clock) disable iff (rst)
        num_dispatch <= occ_cnt);

endmodule

`default_nettype wire

/* source/lane_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface lane_if;
    import dispatch_pkg::*;

    logic          valid;
    decoded_inst_t pkt;
    // branch, jal or jalr
    logic          is_branch;
    // load or store
    logic          is_mem;

    modport decoder (
        output valid,
        output pkt,
        output is_branch,
        output is_mem
    );

    modport selector (
        input valid,
        input pkt,
        input is_branch,
        input is_mem
    );

endinterface

`default_nettype wire

/* source/dispatch_pkg.sv */
`default_nettype none

`include "dispatch_defines.svh"

package dispatch_pkg;

    // store-queue tag width
    localparam int SQ_TAG_W = $clog2(`SQ_SZ);

    // rv32i base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [2:0] {
        CLS_ALU     = 3'd0,
        CLS_LOAD    = 3'd1,
        CLS_STORE   = 3'd2,
        CLS_BRANCH  = 3'd3,
        CLS_ILLEGAL = 3'd4
    } inst_class_t;

    // one decoded lane, as handed to the back end
    typedef struct packed {
        logic                valid;
        inst_class_t         cls;
        logic                illegal;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic                uses_rd;
        logic [31:0]         inst;
        // filled in by the selector for loads and stores
        logic [SQ_TAG_W-1:0] sq_tag;
    } decoded_inst_t;

    // one instruction buffer entry
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
    } fetch_slot_t;

endpackage

`default_nettype wire

/* source/dispatch_defines.svh */
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// dispatch width, instructions per bundle
`define DISP_N 4

// store-queue entries, must be a power of two
`define SQ_SZ 16

// holds a count from 0 to DISP_N
`define DISP_CNT_W $clog2(`DISP_N + 1)

`endif
